// File: dsp_pkg.sv
package dsp_pkg;

	// Datapath and storage sizes.
	localparam int data_width       = 16;
	localparam int n_blocks         = 16;
	localparam int block_addr_width = 4;
	localparam int reg_addr_width   = 4;
	localparam int mem_addr_width   = 4;
	localparam int shift_width      = 3;
	localparam int instr_width      = 32;
	localparam int n_regs           = 16;  // Per block.
	localparam int n_channels       = 16;
	localparam int n_mem_words      = 16;

	localparam logic signed [data_width-1:0] sample_max = 16'sh7fff;
	localparam logic signed [data_width-1:0] sample_min = 16'sh8000;

	// Bit positions inside the instruction word.
	localparam int op_msb        = 31;
	localparam int op_lsb        = 28;
	localparam int src_a_msb     = 27;
	localparam int src_a_lsb     = 24;
	localparam int src_a_reg_bit = 23;
	localparam int src_b_msb     = 22;
	localparam int src_b_lsb     = 19;
	localparam int src_b_reg_bit = 18;
	localparam int src_c_msb     = 17;
	localparam int src_c_lsb     = 14;
	localparam int src_c_reg_bit = 13;
	localparam int dest_msb      = 12;
	localparam int dest_lsb      = 9;
	localparam int dest_reg_bit  = 8;
	localparam int saturate_bit  = 7;
	localparam int shift_msb     = 6;
	localparam int shift_lsb     = 4;
	localparam int res_addr_msb  = 3;
	localparam int res_addr_lsb  = 0;

	typedef enum logic [3:0] {
		op_nop  = 4'd0,
		op_add  = 4'd1,
		op_sub  = 4'd2,
		op_lsh  = 4'd3,
		op_rsh  = 4'd4,
		op_arsh = 4'd5,
		op_mul  = 4'd6,
		op_mad  = 4'd7,
		op_abs  = 4'd8,
		op_save = 4'd9,
		op_load = 4'd10,
		op_mov  = 4'd11
	} block_op_t;

	typedef enum logic [3:0] {
		st_idle,
		st_fetch,
		st_decode,
		st_get_a,
		st_get_b,
		st_get_c,
		st_exec,
		st_wait,
		st_load,
		st_write,
		st_next,
		st_finish
	} seq_state_t;

endpackage

// File: program_loader.sv
`timescale 1ns/1ns

module program_loader (
	input  logic clk,
	input  logic reset,
	input  logic command_instr_write,
	input  logic command_reg_write,
	input  logic [dsp_pkg::block_addr_width-1:0] command_block_target,
	input  logic [dsp_pkg::instr_width-1:0] command_instr_write_val,
	input  logic [dsp_pkg::block_addr_width-1:0] block_sel,
	input  logic reg_write_taken,
	output logic [dsp_pkg::instr_width-1:0] instr,
	output logic [dsp_pkg::block_addr_width-1:0] last_block,
	output logic reg_write_pending,
	output logic instr_write_ack,
	output logic reg_write_ack
);
	import dsp_pkg::*;

	logic [instr_width-1:0] instr_mem [n_blocks];
	logic reg_write_prev;

	always_ff @(posedge clk) begin
		if (command_instr_write)
			instr_mem[command_block_target] <= command_instr_write_val;
		instr <= instr_mem[block_sel];  // Valid one cycle after the slot is addressed.
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			last_block <= '0;
			reg_write_prev <= 1'b0;
			reg_write_pending <= 1'b0;
			instr_write_ack <= 1'b0;
			reg_write_ack <= 1'b0;
		end else begin
			instr_write_ack <= command_instr_write;
			reg_write_ack <= reg_write_taken;
			reg_write_prev <= command_reg_write;
			if (command_instr_write && command_block_target > last_block)
				last_block <= command_block_target;
			// A new request edge wins over the sequencer taking the old one.
			if (command_reg_write && !reg_write_prev)
				reg_write_pending <= 1'b1;
			else if (reg_write_taken)
				reg_write_pending <= 1'b0;
		end
	end

endmodule

// File: operand_store.sv
`timescale 1ns/1ns

module operand_store (
	input  logic clk,
	input  logic reset,
	input  logic [dsp_pkg::block_addr_width-1:0] rd_block,
	input  logic [dsp_pkg::reg_addr_width-1:0] rd_addr,
	input  logic rd_is_reg,
	input  logic wr_en,
	input  logic [dsp_pkg::block_addr_width-1:0] wr_block,
	input  logic [dsp_pkg::reg_addr_width-1:0] wr_addr,
	input  logic wr_is_reg,
	input  logic signed [dsp_pkg::data_width-1:0] wr_data,
	input  logic mem_wr_en,
	input  logic [dsp_pkg::mem_addr_width-1:0] mem_addr,
	input  logic signed [dsp_pkg::data_width-1:0] mem_wr_data,
	input  logic sample_load,
	input  logic signed [dsp_pkg::data_width-1:0] sample_in,
	output logic signed [dsp_pkg::data_width-1:0] rd_data,
	output logic signed [dsp_pkg::data_width-1:0] mem_rd_data
);
	import dsp_pkg::*;

	// Block registers are addressed as {block, register}.
	logic signed [data_width-1:0] block_regs [n_blocks * n_regs];
	logic signed [data_width-1:0] channels [n_channels];
	logic signed [data_width-1:0] memory [n_mem_words];

	always_ff @(posedge clk) begin
		if (wr_en && wr_is_reg)
			block_regs[{wr_block, wr_addr}] <= wr_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < n_channels; i++)
				channels[i] <= '0;
		end else begin
			if (wr_en && !wr_is_reg)
				channels[wr_addr] <= wr_data;
			if (sample_load)
				channels[0] <= sample_in;  // The core never writes back during a load.
		end
	end

	always_ff @(posedge clk) begin
		if (rd_is_reg)
			rd_data <= block_regs[{rd_block, rd_addr}];
		else
			rd_data <= channels[rd_addr];
	end

	// The data memory shares one address between its read and write port.
	always_ff @(posedge clk) begin
		if (mem_wr_en)
			memory[mem_addr] <= mem_wr_data;
		mem_rd_data <= memory[mem_addr];
	end

endmodule

// File: arith_unit.sv
`timescale 1ns/1ns

module arith_unit (
	input  logic clk,
	input  logic reset,
	input  logic op_start,
	input  dsp_pkg::block_op_t op,
	input  logic signed [dsp_pkg::data_width-1:0] a,
	input  logic signed [dsp_pkg::data_width-1:0] b,
	input  logic signed [dsp_pkg::data_width-1:0] c,
	input  logic saturate,
	input  logic [dsp_pkg::shift_width-1:0] shift,
	output logic signed [dsp_pkg::data_width-1:0] result,
	output logic result_valid
);
	import dsp_pkg::*;

	block_op_t op_q;
	logic sat_q;
	logic [shift_width-1:0] shift_q;
	logic signed [data_width-1:0] c_q;
	logic signed [data_width:0] b_ext;
	logic signed [data_width:0] add_a;
	logic signed [data_width:0] add_b;
	logic signed [data_width:0] add_sum;
	logic signed [data_width-1:0] add_out;
	logic signed [2*data_width-1:0] product;
	logic signed [2*data_width-1:0] product_shifted;
	logic signed [data_width-1:0] mul_out;
	logic [shift_width:0] mul_shift;
	logic signed [data_width-1:0] simple_out;
	logic is_simple;
	logic sum_valid;
	logic prod_valid;
	logic shifted_valid;

	// Clip to the sample range when saturating, otherwise keep the low bits.
	function automatic logic signed [data_width-1:0] clip(
		input logic signed [2*data_width-1:0] v,
		input logic sat
	);
		if (sat && v > sample_max)
			return sample_max;
		if (sat && v < sample_min)
			return sample_min;
		return v[data_width-1:0];
	endfunction

	assign b_ext = b;
	assign add_sum = add_a + add_b;  // Exact in 17 bits.
	assign add_out = clip(add_sum, sat_q);
	assign mul_shift = (shift_width + 1)'(data_width - 1) - {1'b0, shift_q};
	assign mul_out = clip(product_shifted, sat_q);
	assign is_simple = !(op inside {op_add, op_sub, op_mul, op_mad});

	always_comb begin
		case (op)
			op_abs:  simple_out = (a < 0) ? -a : a;  // -32768 wraps onto itself.
			op_lsh:  simple_out = {a[data_width-2:0], 1'b0};
			op_rsh:  simple_out = {1'b0, a[data_width-1:1]};
			op_arsh: simple_out = a >>> 1;
			default: simple_out = a;
		endcase
	end

	always_ff @(posedge clk) begin
		if (op_start) begin
			op_q <= op;
			sat_q <= saturate;
			shift_q <= shift;
			c_q <= c;
			product <= a * b;
			add_a <= a;
			add_b <= (op == op_sub) ? -b_ext : b_ext;
		end
		product_shifted <= product >>> mul_shift;
		// The MAD tail reuses the adder with the clipped product.
		if (shifted_valid) begin
			add_a <= mul_out;
			add_b <= c_q;
		end
		if (op_start && is_simple)
			result <= simple_out;
		else if (sum_valid)
			result <= add_out;
		else if (shifted_valid && op_q == op_mul)
			result <= mul_out;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			sum_valid <= 1'b0;
			prod_valid <= 1'b0;
			shifted_valid <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			sum_valid <= (op_start && (op == op_add || op == op_sub)) ||
				(shifted_valid && op_q == op_mad);
			prod_valid <= op_start && (op == op_mul || op == op_mad);
			shifted_valid <= prod_valid;
			result_valid <= (op_start && is_simple) || sum_valid ||
				(shifted_valid && op_q == op_mul);
		end
	end

endmodule

// File: block_sequencer.sv
`timescale 1ns/1ns

module block_sequencer (
	input  logic clk,
	input  logic reset,
	input  logic tick,
	input  logic [dsp_pkg::instr_width-1:0] instr,
	input  logic [dsp_pkg::block_addr_width-1:0] last_block,
	input  logic reg_write_pending,
	input  logic signed [dsp_pkg::data_width-1:0] rd_data,
	input  logic signed [dsp_pkg::data_width-1:0] mem_rd_data,
	input  logic signed [dsp_pkg::data_width-1:0] result,
	input  logic result_valid,
	input  logic [dsp_pkg::block_addr_width-1:0] command_block_target,
	input  logic [dsp_pkg::reg_addr_width-1:0] command_reg_target,
	input  logic signed [dsp_pkg::data_width-1:0] command_reg_write_val,
	output logic ready,
	output logic signed [dsp_pkg::data_width-1:0] sample_out,
	output logic [dsp_pkg::block_addr_width-1:0] block_sel,
	output logic reg_write_taken,
	output logic [dsp_pkg::block_addr_width-1:0] rd_block,
	output logic [dsp_pkg::reg_addr_width-1:0] rd_addr,
	output logic rd_is_reg,
	output logic wr_en,
	output logic [dsp_pkg::block_addr_width-1:0] wr_block,
	output logic [dsp_pkg::reg_addr_width-1:0] wr_addr,
	output logic wr_is_reg,
	output logic signed [dsp_pkg::data_width-1:0] wr_data,
	output logic mem_wr_en,
	output logic [dsp_pkg::mem_addr_width-1:0] mem_addr,
	output logic signed [dsp_pkg::data_width-1:0] mem_wr_data,
	output logic sample_load,
	output logic op_start,
	output dsp_pkg::block_op_t op,
	output logic signed [dsp_pkg::data_width-1:0] a,
	output logic signed [dsp_pkg::data_width-1:0] b,
	output logic signed [dsp_pkg::data_width-1:0] c,
	output logic saturate,
	output logic [dsp_pkg::shift_width-1:0] shift
);
	import dsp_pkg::*;

	seq_state_t state;
	logic [reg_addr_width-1:0] src_b_q;
	logic src_b_reg_q;
	logic [reg_addr_width-1:0] src_c_q;
	logic src_c_reg_q;
	logic [reg_addr_width-1:0] dest_q;
	logic dest_reg_q;
	logic [mem_addr_width-1:0] res_addr_q;
	logic signed [data_width-1:0] work;

	// A tick wins over a host register write in the same idle cycle.
	assign sample_load = (state == st_idle) && ready && tick;
	assign reg_write_taken = (state == st_idle) && reg_write_pending && !sample_load;

	assign rd_block = block_sel;
	assign wr_en = reg_write_taken || (state == st_write);
	assign wr_block = reg_write_taken ? command_block_target : block_sel;
	assign wr_addr = reg_write_taken ? command_reg_target : dest_q;
	assign wr_is_reg = reg_write_taken || dest_reg_q;
	assign wr_data = reg_write_taken ? command_reg_write_val : work;

	assign mem_addr = res_addr_q;
	assign mem_wr_en = (state == st_exec) && (op == op_save);
	assign mem_wr_data = a;
	assign op_start = (state == st_exec) && !(op inside {op_nop, op_save, op_load});

	// Channel 0 is read by default, so it is ready for sample_out after the last block.
	always_comb begin
		rd_addr = '0;
		rd_is_reg = 1'b0;
		case (state)
			st_decode: begin
				rd_addr = instr[src_a_msb:src_a_lsb];
				rd_is_reg = instr[src_a_reg_bit];
			end
			st_get_a: begin
				rd_addr = src_b_q;
				rd_is_reg = src_b_reg_q;
			end
			st_get_b: begin
				rd_addr = src_c_q;
				rd_is_reg = src_c_reg_q;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			block_sel <= '0;
			ready <= 1'b1;
		end else begin
			case (state)
				st_idle: begin
					ready <= 1'b1;  // Rises one cycle after sample_out is updated.
					if (sample_load) begin
						ready <= 1'b0;
						block_sel <= '0;
						state <= st_fetch;
					end
				end
				st_fetch: state <= st_decode;
				st_decode: state <= st_get_a;
				st_get_a: begin
					case (op)
						op_nop: state <= st_next;
						op_add, op_sub, op_mul, op_mad: state <= st_get_b;
						default: state <= st_exec;
					endcase
				end
				st_get_b: state <= (op == op_mad) ? st_get_c : st_exec;
				st_get_c: state <= st_exec;
				st_exec: begin
					if (op == op_save)
						state <= st_next;
					else if (op == op_load)
						state <= st_load;
					else
						state <= st_wait;
				end
				st_load: state <= st_write;
				st_wait: begin
					if (result_valid)
						state <= st_write;
				end
				st_write: state <= st_next;
				st_next: begin
					if (block_sel == last_block) begin
						state <= st_finish;
					end else begin
						block_sel <= block_sel + 1'b1;
						state <= st_fetch;
					end
				end
				st_finish: state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			st_decode: begin
				op <= block_op_t'(instr[op_msb:op_lsb]);
				src_b_q <= instr[src_b_msb:src_b_lsb];
				src_b_reg_q <= instr[src_b_reg_bit];
				src_c_q <= instr[src_c_msb:src_c_lsb];
				src_c_reg_q <= instr[src_c_reg_bit];
				dest_q <= instr[dest_msb:dest_lsb];
				dest_reg_q <= instr[dest_reg_bit];
				saturate <= instr[saturate_bit];
				shift <= instr[shift_msb:shift_lsb];
				res_addr_q <= instr[res_addr_msb:res_addr_lsb];
			end
			st_get_a: a <= rd_data;
			st_get_b: b <= rd_data;
			st_get_c: c <= rd_data;
			st_load: work <= mem_rd_data;
			st_wait: begin
				if (result_valid)
					work <= result;
			end
			st_finish: sample_out <= rd_data;
			default: ;
		endcase
	end

endmodule

// File: dsp_core.sv
`timescale 1ns/1ns

module dsp_core (
	input  logic clk,
	input  logic reset,
	input  logic tick,
	input  logic signed [dsp_pkg::data_width-1:0] sample_in,
	output logic signed [dsp_pkg::data_width-1:0] sample_out,
	output logic ready,
	input  logic command_instr_write,
	input  logic command_reg_write,
	input  logic [dsp_pkg::block_addr_width-1:0] command_block_target,
	input  logic [dsp_pkg::reg_addr_width-1:0] command_reg_target,
	input  logic [dsp_pkg::instr_width-1:0] command_instr_write_val,
	input  logic signed [dsp_pkg::data_width-1:0] command_reg_write_val,
	output logic instr_write_ack,
	output logic reg_write_ack
);
	import dsp_pkg::*;

	logic [instr_width-1:0] instr;
	logic [block_addr_width-1:0] last_block;
	logic [block_addr_width-1:0] block_sel;
	logic reg_write_pending;
	logic reg_write_taken;
	logic [block_addr_width-1:0] rd_block;
	logic [reg_addr_width-1:0] rd_addr;
	logic rd_is_reg;
	logic signed [data_width-1:0] rd_data;
	logic wr_en;
	logic [block_addr_width-1:0] wr_block;
	logic [reg_addr_width-1:0] wr_addr;
	logic wr_is_reg;
	logic signed [data_width-1:0] wr_data;
	logic mem_wr_en;
	logic [mem_addr_width-1:0] mem_addr;
	logic signed [data_width-1:0] mem_wr_data;
	logic signed [data_width-1:0] mem_rd_data;
	logic sample_load;
	logic op_start;
	block_op_t op;
	logic signed [data_width-1:0] a;
	logic signed [data_width-1:0] b;
	logic signed [data_width-1:0] c;
	logic saturate;
	logic [shift_width-1:0] shift;
	logic signed [data_width-1:0] result;
	logic result_valid;

	program_loader loader (
		.clk(clk), .reset(reset),
		.command_instr_write(command_instr_write), .command_reg_write(command_reg_write),
		.command_block_target(command_block_target),
		.command_instr_write_val(command_instr_write_val),
		.block_sel(block_sel), .reg_write_taken(reg_write_taken),
		.instr(instr), .last_block(last_block), .reg_write_pending(reg_write_pending),
		.instr_write_ack(instr_write_ack), .reg_write_ack(reg_write_ack)
	);

	operand_store store (
		.clk(clk), .reset(reset),
		.rd_block(rd_block), .rd_addr(rd_addr), .rd_is_reg(rd_is_reg),
		.wr_en(wr_en), .wr_block(wr_block), .wr_addr(wr_addr),
		.wr_is_reg(wr_is_reg), .wr_data(wr_data),
		.mem_wr_en(mem_wr_en), .mem_addr(mem_addr), .mem_wr_data(mem_wr_data),
		.sample_load(sample_load), .sample_in(sample_in),
		.rd_data(rd_data), .mem_rd_data(mem_rd_data)
	);

	arith_unit alu (
		.clk(clk), .reset(reset),
		.op_start(op_start), .op(op), .a(a), .b(b), .c(c),
		.saturate(saturate), .shift(shift),
		.result(result), .result_valid(result_valid)
	);

	block_sequencer seq (
		.clk(clk), .reset(reset), .tick(tick),
		.instr(instr), .last_block(last_block), .reg_write_pending(reg_write_pending),
		.rd_data(rd_data), .mem_rd_data(mem_rd_data),
		.result(result), .result_valid(result_valid),
		.command_block_target(command_block_target),
		.command_reg_target(command_reg_target),
		.command_reg_write_val(command_reg_write_val),
		.ready(ready), .sample_out(sample_out),
		.block_sel(block_sel), .reg_write_taken(reg_write_taken),
		.rd_block(rd_block), .rd_addr(rd_addr), .rd_is_reg(rd_is_reg),
		.wr_en(wr_en), .wr_block(wr_block), .wr_addr(wr_addr),
		.wr_is_reg(wr_is_reg), .wr_data(wr_data),
		.mem_wr_en(mem_wr_en), .mem_addr(mem_addr), .mem_wr_data(mem_wr_data),
		.sample_load(sample_load),
		.op_start(op_start), .op(op), .a(a), .b(b), .c(c),
		.saturate(saturate), .shift(shift)
	);

endmodule

// File: tb_dsp_core.sv
`timescale 1ns/1ns

module tb_dsp_core;
	import dsp_pkg::*;

	localparam int wait_limit = 200;  // Cycles allowed for one ack or one run.
	localparam int timeout_cycles = 20000;  // A few times the length of all tests together.

	logic clk;
	logic reset;
	logic tick;
	logic signed [data_width-1:0] sample_in;
	logic signed [data_width-1:0] sample_out;
	logic ready;
	logic command_instr_write;
	logic command_reg_write;
	logic [block_addr_width-1:0] command_block_target;
	logic [reg_addr_width-1:0] command_reg_target;
	logic [instr_width-1:0] command_instr_write_val;
	logic signed [data_width-1:0] command_reg_write_val;
	logic instr_write_ack;
	logic reg_write_ack;

	// Reference copies of everything the host has loaded.
	logic [instr_width-1:0] model_prog [n_blocks];
	logic signed [data_width-1:0] model_regs [n_blocks][n_regs];
	logic signed [data_width-1:0] model_ch [n_channels];
	logic signed [data_width-1:0] model_mem [n_mem_words];
	int model_last;
	logic [31:0] rng;
	int errors;
	int test_errors;
	int tests_run;
	int tests_failed;
	int cycles = 0;

	dsp_core UUT (
		.clk(clk), .reset(reset), .tick(tick),
		.sample_in(sample_in), .sample_out(sample_out), .ready(ready),
		.command_instr_write(command_instr_write), .command_reg_write(command_reg_write),
		.command_block_target(command_block_target),
		.command_reg_target(command_reg_target),
		.command_instr_write_val(command_instr_write_val),
		.command_reg_write_val(command_reg_write_val),
		.instr_write_ack(instr_write_ack), .reg_write_ack(reg_write_ack)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("Timeout: the simulation ran past %0d cycles", timeout_cycles);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		instr_write_ack == $past(command_instr_write))
	else begin
		$display("Mismatch at %0t ns: instr_write_ack is not the strobe delayed by one cycle",
			$time);
		errors++;
	end

	assert property (@(posedge clk) disable iff (reset) reg_write_ack |=> !reg_write_ack)
	else begin
		$display("Mismatch at %0t ns: reg_write_ack lasted more than one cycle", $time);
		errors++;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng = xorshift(rng);
		return rng;
	endfunction

	function automatic logic [31:0] encode(input block_op_t o, input int sa, input int sa_reg,
		input int sb, input int sb_reg, input int sc, input int sc_reg, input int d,
		input int d_reg, input int sat, input int sh, input int ra);
		logic [31:0] w;
		w = '0;
		w[op_msb:op_lsb] = o;
		w[src_a_msb:src_a_lsb] = sa[3:0];
		w[src_a_reg_bit] = sa_reg[0];
		w[src_b_msb:src_b_lsb] = sb[3:0];
		w[src_b_reg_bit] = sb_reg[0];
		w[src_c_msb:src_c_lsb] = sc[3:0];
		w[src_c_reg_bit] = sc_reg[0];
		w[dest_msb:dest_lsb] = d[3:0];
		w[dest_reg_bit] = d_reg[0];
		w[saturate_bit] = sat[0];
		w[shift_msb:shift_lsb] = sh[2:0];
		w[res_addr_msb:res_addr_lsb] = ra[3:0];
		return w;
	endfunction

	function automatic logic signed [15:0] clip_sample(input logic signed [31:0] v,
		input logic sat);
		if (sat && v > sample_max)
			return sample_max;
		if (sat && v < sample_min)
			return sample_min;
		return v[15:0];  // Wraps when not saturating.
	endfunction

	function automatic logic signed [15:0] addsub_rule(input logic signed [15:0] x,
		input logic signed [15:0] y, input logic sub, input logic sat);
		logic signed [31:0] wide_x;
		logic signed [31:0] wide_y;
		wide_x = x;
		wide_y = y;
		return clip_sample(sub ? wide_x - wide_y : wide_x + wide_y, sat);
	endfunction

	function automatic logic signed [15:0] mul_rule(input logic signed [15:0] x,
		input logic signed [15:0] y, input logic [2:0] sh, input logic sat);
		logic signed [31:0] wide_x;
		logic signed [31:0] wide_y;
		logic signed [31:0] product;
		wide_x = x;
		wide_y = y;
		product = wide_x * wide_y;
		return clip_sample(product >>> (15 - sh), sat);
	endfunction

	function automatic logic signed [15:0] read_operand(input int blk, input logic [3:0] idx,
		input logic is_reg);
		return is_reg ? model_regs[blk][idx] : model_ch[idx];
	endfunction

	// Runs the loaded program on the reference copies and returns channel 0.
	task automatic model_run(input logic signed [15:0] smp, output logic signed [15:0] expected);
		logic [31:0] w;
		block_op_t o;
		logic signed [15:0] va;
		logic signed [15:0] vb;
		logic signed [15:0] vc;
		logic signed [15:0] res;
		logic has_dest;
		model_ch[0] = smp;
		for (int s = 0; s <= model_last; s++) begin
			w = model_prog[s];
			o = block_op_t'(w[op_msb:op_lsb]);
			va = read_operand(s, w[src_a_msb:src_a_lsb], w[src_a_reg_bit]);
			vb = read_operand(s, w[src_b_msb:src_b_lsb], w[src_b_reg_bit]);
			vc = read_operand(s, w[src_c_msb:src_c_lsb], w[src_c_reg_bit]);
			has_dest = 1'b1;
			res = va;
			case (o)
				op_add: res = addsub_rule(va, vb, 1'b0, w[saturate_bit]);
				op_sub: res = addsub_rule(va, vb, 1'b1, w[saturate_bit]);
				op_mul: res = mul_rule(va, vb, w[shift_msb:shift_lsb], w[saturate_bit]);
				op_mad: res = addsub_rule(mul_rule(va, vb, w[shift_msb:shift_lsb],
					w[saturate_bit]), vc, 1'b0, w[saturate_bit]);
				op_lsh: res = va << 1;
				op_rsh: res = va >> 1;
				op_arsh: res = va >>> 1;
				op_abs: res = (va == sample_min || va >= 0) ? va : -va;
				op_load: res = model_mem[w[res_addr_msb:res_addr_lsb]];
				op_save: begin
					model_mem[w[res_addr_msb:res_addr_lsb]] = va;
					has_dest = 1'b0;
				end
				op_nop: has_dest = 1'b0;
				default: res = va;
			endcase
			if (has_dest && w[dest_reg_bit])
				model_regs[s][w[dest_msb:dest_lsb]] = res;
			else if (has_dest)
				model_ch[w[dest_msb:dest_lsb]] = res;
		end
		expected = model_ch[0];
	endtask

	task automatic check_value(input logic signed [31:0] got, input logic signed [31:0] exp,
		input string what);
		assert (got === exp)
		else begin
			$display("Mismatch at %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic start_test();
		test_errors = errors;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors != test_errors) begin
			tests_failed++;
			$display("Test %0d, %s: failed with %0d errors", tests_run, name,
				errors - test_errors);
		end else begin
			$display("Test %0d, %s: passed", tests_run, name);
		end
	endtask

	task automatic write_instr(input int slot, input logic [31:0] word);
		@(negedge clk);
		command_block_target = slot[3:0];
		command_instr_write_val = word;
		command_instr_write = 1'b1;
		@(negedge clk);
		command_instr_write = 1'b0;
		check_value(instr_write_ack, 1, "instr_write_ack one cycle after the strobe");
		@(negedge clk);
		check_value(instr_write_ack, 0, "instr_write_ack after one cycle");
		model_prog[slot] = word;
		if (slot > model_last)
			model_last = slot;
	endtask

	task automatic write_reg(input int blk, input int r, input logic signed [15:0] val);
		int acks;
		int n;
		acks = 0;
		n = 0;
		@(negedge clk);
		command_block_target = blk[3:0];
		command_reg_target = r[3:0];
		command_reg_write_val = val;
		command_reg_write = 1'b1;
		while (acks == 0 && n < wait_limit) begin
			@(negedge clk);
			n++;
			if (reg_write_ack)
				acks++;
		end
		// The command is still held here, so a second write would show up as a second ack.
		for (int k = 0; k < 6; k++) begin
			@(negedge clk);
			if (k == 3)
				command_reg_write = 1'b0;
			if (reg_write_ack)
				acks++;
		end
		if (n >= wait_limit) begin
			$display("Timeout at %0t ns: no reg_write_ack for a register write", $time);
			errors++;
		end else begin
			check_value(acks, 1, "reg_write_ack count for one held command");
		end
		model_regs[blk][r] = val;
	endtask

	task automatic run_checked(input logic signed [15:0] smp, input logic noisy,
		input string what);
		logic signed [15:0] expected;
		logic [31:0] r;
		int n;
		model_run(smp, expected);
		@(negedge clk);
		check_value(ready, 1, "ready before a tick");
		sample_in = smp;
		tick = 1'b1;
		@(negedge clk);
		tick = 1'b0;
		check_value(ready, 0, "ready after an accepted tick");
		n = 0;
		while (!ready && n < wait_limit) begin
			if (noisy) begin
				r = next_random();  // Ticks during a run must not touch channel 0.
				tick = r[0];
				sample_in = r[31:16];
			end
			@(negedge clk);
			n++;
		end
		tick = 1'b0;
		if (n >= wait_limit) begin
			$display("Timeout at %0t ns: ready did not rise after a tick (%s)", $time, what);
			errors++;
		end else begin
			check_value(sample_out, expected, what);
		end
	endtask

	initial begin
		logic signed [15:0] a_val;
		logic signed [15:0] b_val;
		logic signed [15:0] c_val;
		logic [31:0] r;
		block_op_t o;
		block_op_t shift_ops [4];
		logic signed [15:0] chain_in [4];
		int sat;
		int sh;
		int m;
		reset = 1'b1;
		tick = 1'b0;
		sample_in = '0;
		command_instr_write = 1'b0;
		command_reg_write = 1'b0;
		command_block_target = '0;
		command_reg_target = '0;
		command_instr_write_val = '0;
		command_reg_write_val = '0;
		rng = 32'd70;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		model_last = 0;
		shift_ops = '{op_lsh, op_rsh, op_arsh, op_mov};
		chain_in = '{16'sh8000, -16'sd3, -16'sd5, 16'sh8000};
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		start_test();
		check_value(ready, 1, "ready after reset");
		check_value(instr_write_ack, 0, "instr_write_ack after reset");
		check_value(reg_write_ack, 0, "reg_write_ack after reset");
		write_instr(0, encode(op_nop, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0));
		finish_test("reset state and instruction write ack");

		start_test();
		r = next_random();
		write_reg(0, 5, r[15:0]);
		write_instr(0, encode(op_mov, 5, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0));
		run_checked(r[31:16], 1'b0, "MOV from a block register");
		finish_test("held register write and MOV");

		start_test();
		for (int i = 0; i < 24; i++) begin
			r = next_random();
			if (i < 16) begin
				a_val = i[1] ? sample_min : sample_max;  // Extreme pairs first.
				b_val = i[2] ? sample_min : sample_max;
			end else begin
				a_val = r[15:0];
				b_val = r[31:16];
			end
			o = ((i < 16) ? i[3] : r[4]) ? op_sub : op_add;
			sat = (i < 16) ? i[0] : r[9];
			write_reg(0, 2, b_val);
			write_instr(0, encode(o, 0, 0, 2, 1, 0, 0, 0, 0, sat, 0, 0));
			run_checked(a_val, 1'b0, "ADD or SUB of sample and register");
		end
		finish_test("ADD and SUB");

		start_test();
		for (int i = 0; i < 16; i++) begin
			r = next_random();
			a_val = (i < 4) ? sample_min : r[15:0];
			b_val = (i < 4) ? sample_min : r[31:16];
			r = next_random();
			c_val = r[15:0];
			sat = (i < 4) ? i[1] : r[16];
			sh = (i < 4) ? 0 : r[19:17];
			o = i[0] ? op_mad : op_mul;
			write_reg(0, 1, b_val);
			write_reg(0, 2, c_val);
			write_instr(0, encode(o, 0, 0, 1, 1, 2, 1, 0, 0, sat, sh, 0));
			run_checked(a_val, 1'b0, "MUL or MAD of sample and registers");
		end
		finish_test("MUL and MAD");

		start_test();
		for (int i = 0; i < 8; i++) begin
			r = next_random();
			m = r[3:0];
			a_val = (i < 4) ? chain_in[i] : r[31:16];
			o = shift_ops[i % 4];
			write_instr(0, encode(op_save, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, m));
			write_instr(1, encode(op_load, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, m));
			write_instr(2, encode(o, 1, 0, 0, 0, 0, 0, 2, 0, 0, 0, 0));
			write_instr(3, encode((i < 4) ? op_abs : op_mov, 2, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0));
			run_checked(a_val, 1'b1, "SAVE, LOAD, shift and ABS chain");
		end
		finish_test("four block chain with ticks during the run");

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: all.f
dsp_pkg.sv
program_loader.sv
operand_store.sv
arith_unit.sv
block_sequencer.sv
dsp_core.sv
tb_dsp_core.sv

// File: run.sh
#!/bin/bash
# Builds the testbench with Verilator, runs it and checks the log for a failure.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
	--top-module tb_dsp_core -f all.f > build.log 2>&1 \
	&& ./obj_dir/Vtb_dsp_core > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "Simulation reported errors"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "Simulation ended without a verdict"; exit 1; }
exit 0
